/* tb.f */
hdl/rca_pkg.sv
hdl/grid_xbar_mux.sv
hdl/grid_io_block.sv
hdl/grid_pr_slot.sv
hdl/grid_row.sv
hdl/rca_pr_grid.sv
sim/rca_pr_grid_assertions.sv
sim/rca_pr_grid_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the grid testbench with Verilator, verdict from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module rca_pr_grid_tb \
    -o rca_pr_grid_sim \
    && ./obj_dir/rca_pr_grid_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TEST PASSED$" sim.log 2>/dev/null \
    && echo "simulation result: pass" && exit 0 \
    || { echo "simulation result: fail"; exit 1; }

/* sim/rca_pr_grid_tb.sv */
`timescale 1ns/1ns

module rca_pr_grid_tb;

    logic clk;
    logic rst;
    logic [rca_pkg::XLEN-1:0] rs_vals [rca_pkg::NUM_READ_PORTS];
    logic [rca_pkg::GRID_NUM_ROWS-1:0] rs_data_valid;
    rca_pkg::io_cfg_t io_cfg [rca_pkg::GRID_NUM_ROWS];
    rca_pkg::slot_cfg_t slot_cfg [rca_pkg::GRID_NUM_ROWS][rca_pkg::GRID_NUM_COLS];
    logic io_units_rst;
    logic [rca_pkg::GRID_NUM_ROWS-1:0] io_fifo_pop;
    rca_pkg::grid_word_t io_unit_out [rca_pkg::GRID_NUM_ROWS];
    rca_pkg::grid_word_t grid_out [rca_pkg::GRID_NUM_COLS];

    int num_checks;
    int num_errors;
    int num_timeouts;

    rca_pr_grid UUT (
        .clk(clk),
        .rst(rst),
        .rs_vals(rs_vals),
        .rs_data_valid(rs_data_valid),
        .io_cfg(io_cfg),
        .slot_cfg(slot_cfg),
        .io_units_rst(io_units_rst),
        .io_fifo_pop(io_fifo_pop),
        .io_unit_out(io_unit_out),
        .grid_out(grid_out)
    );

    bind grid_io_block rca_pr_grid_assertions io_checks (
        .clk(clk),
        .rst(rst),
        .data_in(data_in),
        .output_mode(output_mode),
        .fifo_rst(fifo_rst),
        .fifo_pop(fifo_pop),
        .fifo_count(fifo_count),
        .data_out(data_out)
    );

    always #50 clk = ~clk;

    // mul keeps the low word of the full product
    function automatic logic [rca_pkg::XLEN-1:0] apply_op(
        input rca_pkg::slot_op_t op,
        input logic [rca_pkg::XLEN-1:0] a,
        input logic [rca_pkg::XLEN-1:0] b
    );
        logic [2*rca_pkg::XLEN-1:0] product;
        product = {{rca_pkg::XLEN{1'b0}}, a} * {{rca_pkg::XLEN{1'b0}}, b};
        case (op)
            rca_pkg::SLOT_ADD: return a + b;
            rca_pkg::SLOT_SUB: return a - b;
            rca_pkg::SLOT_XOR: return a ^ b;
            default: return product[rca_pkg::XLEN-1:0];
        endcase
    endfunction

    function automatic rca_pkg::grid_word_t word_of(input logic [rca_pkg::XLEN-1:0] data);
        rca_pkg::grid_word_t w;
        w.valid = 1'b1;
        w.data = data;
        return w;
    endfunction

    task automatic check_word(
        input string test,
        input rca_pkg::grid_word_t expected,
        input rca_pkg::grid_word_t actual
    );
        num_checks++;
        if (actual !== expected) begin
            num_errors++;
            $display("FAILED %s: expected valid=%0b data=%08h, actual valid=%0b data=%08h",
                     test, expected.valid, expected.data, actual.valid, actual.data);
        end
    endtask

    task automatic check_op(
        input string test,
        input rca_pkg::slot_op_t op,
        input logic [rca_pkg::XLEN-1:0] a,
        input logic [rca_pkg::XLEN-1:0] b,
        input rca_pkg::grid_word_t actual
    );
        check_word($sformatf("%s %s", test, op.name()), word_of(apply_op(op, a, b)), actual);
    endtask

    task automatic expect_invalid(input string test, input rca_pkg::grid_word_t actual);
        num_checks++;
        if (actual.valid !== 1'b0) begin
            num_errors++;
            $display("FAILED %s: expected valid=0, actual valid=%0b", test, actual.valid);
        end
    endtask

    task automatic all_outputs_idle(input string test);
        for (int r = 0; r < rca_pkg::GRID_NUM_ROWS; r++) begin
            expect_invalid($sformatf("%s io_unit_out[%0d]", test, r), io_unit_out[r]);
        end
        for (int c = 0; c < rca_pkg::GRID_NUM_COLS; c++) begin
            expect_invalid($sformatf("%s grid_out[%0d]", test, c), grid_out[c]);
        end
    endtask

    task automatic wait_valid(input string test, input bit from_grid, input int idx);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < 20) begin
            @(negedge clk);
            cycles++;
            seen = from_grid ? (grid_out[idx].valid === 1'b1)
                             : (io_unit_out[idx].valid === 1'b1);
        end
        if (!seen) begin
            num_timeouts++;
            $display("%s: %s[%0d] never became valid within 20 cycles",
                     test, from_grid ? "grid_out" : "io_unit_out", idx);
        end
    endtask

    task automatic drain_grid(input string test);
        int cycles;
        bit busy;
        cycles = 0;
        busy = 1'b1;
        while (busy && cycles < 20) begin
            @(negedge clk);
            cycles++;
            busy = 1'b0;
            for (int r = 0; r < rca_pkg::GRID_NUM_ROWS; r++) begin
                busy |= (io_unit_out[r].valid !== 1'b0);
            end
            for (int c = 0; c < rca_pkg::GRID_NUM_COLS; c++) begin
                busy |= (grid_out[c].valid !== 1'b0);
            end
        end
        if (busy) begin
            num_timeouts++;
            $display("%s: grid outputs stayed valid 20 cycles after the inputs went idle", test);
        end
    endtask

    task automatic load_defaults();
        @(posedge clk);
        rs_data_valid <= '0;
        io_fifo_pop <= '0;
        io_units_rst <= 1'b0;
        for (int r = 0; r < rca_pkg::GRID_NUM_ROWS; r++) begin
            io_cfg[r] <= '0;
            for (int c = 0; c < rca_pkg::GRID_NUM_COLS; c++) begin
                slot_cfg[r][c] <= '0;
            end
        end
    endtask

    task automatic pop_fifo();
        @(posedge clk);
        io_fifo_pop[0] <= 1'b1;
        @(posedge clk);
        io_fifo_pop[0] <= 1'b0;
        @(negedge clk);
    endtask

    task automatic reset_behavior();
        // rst is sampled high on 16 rising edges
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i == 15) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            all_outputs_idle("reset");
        end
        @(negedge clk);
        all_outputs_idle("after_reset");
    endtask

    task automatic pass_through();
        logic [rca_pkg::XLEN-1:0] a;
        logic [rca_pkg::XLEN-1:0] b;
        a = $urandom();
        b = $urandom();
        load_defaults();
        @(posedge clk);
        rs_vals[0] <= a;
        rs_vals[1] <= b;
        io_cfg[0] <= '{mux_sel: 3'd0, output_mode: 1'b0, row_const: '0};
        io_cfg[1] <= '{mux_sel: 3'd1, output_mode: 1'b0, row_const: '0};
        rs_data_valid <= 2'b11;
        @(negedge clk);
        // not captured yet
        expect_invalid("pass_mode early row0", io_unit_out[0]);
        expect_invalid("pass_mode early row1", io_unit_out[1]);
        @(negedge clk);
        check_word("pass_mode row0", word_of(a), io_unit_out[0]);
        check_word("pass_mode row1", word_of(b), io_unit_out[1]);
        @(posedge clk);
        rs_data_valid <= '0;
        drain_grid("pass_mode");
    endtask

    task automatic constant_select();
        logic [rca_pkg::XLEN-1:0] c0;
        logic [rca_pkg::XLEN-1:0] c1;
        c0 = $urandom();
        c1 = $urandom();
        load_defaults();
        @(posedge clk);
        io_cfg[0] <= '{mux_sel: 3'd4, output_mode: 1'b0, row_const: c0};
        io_cfg[1] <= '{mux_sel: 3'd4, output_mode: 1'b0, row_const: c1};
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            expect_invalid("constant no valid row0", io_unit_out[0]);
            expect_invalid("constant no valid row1", io_unit_out[1]);
        end
        @(posedge clk);
        rs_data_valid <= 2'b01;
        wait_valid("constant row0", 1'b0, 0);
        check_word("constant row0", word_of(c0), io_unit_out[0]);
        expect_invalid("constant row1 idle", io_unit_out[1]);
        @(posedge clk);
        rs_data_valid <= 2'b10;
        wait_valid("constant row1", 1'b0, 1);
        check_word("constant row1", word_of(c1), io_unit_out[1]);
        expect_invalid("constant row0 idle", io_unit_out[0]);
        @(posedge clk);
        rs_data_valid <= '0;
        drain_grid("constant");
    endtask

    task automatic row0_slot_ops();
        rca_pkg::slot_op_t op;
        logic [rca_pkg::XLEN-1:0] a;
        for (int k = 0; k < 4; k++) begin
            op = rca_pkg::slot_op_t'(k);
            a = $urandom();
            load_defaults();
            @(posedge clk);
            rs_vals[0] <= a;
            io_cfg[1] <= '{mux_sel: 3'd2, output_mode: 1'b0, row_const: '0};
            slot_cfg[0][0] <= '{sel1: 2'd2, sel2: 2'd2, op: op};
            slot_cfg[0][1] <= '{sel1: 2'd2, sel2: 2'd3, op: op};
            rs_data_valid <= 2'b01;
            wait_valid("slot_ops col0", 1'b0, 1);
            check_op("slot_ops col0", op, a, a, io_unit_out[1]);
            // row 1 io switches to slot 1 and shows it one pass register later
            @(posedge clk);
            io_cfg[1].mux_sel <= 3'd3;
            @(posedge clk);
            @(negedge clk);
            check_op("slot_ops col1", op, a, apply_op(op, a, a), io_unit_out[1]);
            @(posedge clk);
            rs_data_valid <= '0;
            drain_grid("slot_ops");
        end
        load_defaults();
        @(posedge clk);
        rs_vals[0] <= $urandom();
        io_cfg[1] <= '{mux_sel: 3'd2, output_mode: 1'b0, row_const: '0};
        // left neighbour of column 0 is an empty word
        slot_cfg[0][0] <= '{sel1: 2'd2, sel2: 2'd3, op: rca_pkg::SLOT_ADD};
        rs_data_valid <= 2'b01;
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            expect_invalid("slot_zero_operand", io_unit_out[1]);
        end
        @(posedge clk);
        rs_data_valid <= '0;
        drain_grid("slot_zero_operand");
    endtask

    task automatic downward_chain();
        logic [rca_pkg::XLEN-1:0] a;
        logic [rca_pkg::XLEN-1:0] b;
        logic [rca_pkg::XLEN-1:0] s00;
        logic [rca_pkg::XLEN-1:0] s01;
        logic [rca_pkg::XLEN-1:0] s10;
        a = $urandom();
        b = $urandom();
        s00 = apply_op(rca_pkg::SLOT_MUL, a, a);
        s01 = apply_op(rca_pkg::SLOT_ADD, a, s00);
        s10 = apply_op(rca_pkg::SLOT_SUB, s00, b);
        load_defaults();
        @(posedge clk);
        rs_vals[0] <= a;
        rs_vals[1] <= b;
        io_cfg[1] <= '{mux_sel: 3'd1, output_mode: 1'b0, row_const: '0};
        slot_cfg[0][0] <= '{sel1: 2'd2, sel2: 2'd2, op: rca_pkg::SLOT_MUL};
        slot_cfg[0][1] <= '{sel1: 2'd2, sel2: 2'd3, op: rca_pkg::SLOT_ADD};
        slot_cfg[1][0] <= '{sel1: 2'd0, sel2: 2'd2, op: rca_pkg::SLOT_SUB};
        slot_cfg[1][1] <= '{sel1: 2'd1, sel2: 2'd3, op: rca_pkg::SLOT_XOR};
        rs_data_valid <= 2'b11;
        // column 1 of the last row is the deepest point
        wait_valid("chain", 1'b1, 1);
        check_op("chain col0", rca_pkg::SLOT_SUB, s00, b, grid_out[0]);
        check_op("chain col1", rca_pkg::SLOT_XOR, s01, s10, grid_out[1]);
        @(posedge clk);
        rs_data_valid <= '0;
        drain_grid("chain");
    endtask

    task automatic fifo_buffering();
        logic [rca_pkg::XLEN-1:0] words [6];
        logic [rca_pkg::XLEN-1:0] fresh;
        for (int i = 0; i < 6; i++) begin
            words[i] = $urandom();
        end
        fresh = $urandom();
        load_defaults();
        @(posedge clk);
        io_cfg[0] <= '{mux_sel: 3'd0, output_mode: 1'b1, row_const: '0};
        @(negedge clk);
        expect_invalid("fifo start empty", io_unit_out[0]);
        // the last two pushes find the fifo full
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            rs_vals[0] <= words[i];
            rs_data_valid <= 2'b01;
        end
        @(posedge clk);
        rs_data_valid <= '0;
        wait_valid("fifo fill", 1'b0, 0);
        for (int i = 0; i < 4; i++) begin
            check_word($sformatf("fifo order %0d", i), word_of(words[i]), io_unit_out[0]);
            pop_fifo();
        end
        expect_invalid("fifo drained", io_unit_out[0]);
        pop_fifo();
        expect_invalid("fifo pop when empty", io_unit_out[0]);
        for (int i = 0; i < 2; i++) begin
            @(posedge clk);
            rs_vals[0] <= words[i + 4];
            rs_data_valid <= 2'b01;
        end
        @(posedge clk);
        rs_data_valid <= '0;
        @(negedge clk);
        check_word("fifo refill", word_of(words[4]), io_unit_out[0]);
        @(posedge clk);
        io_units_rst <= 1'b1;
        @(posedge clk);
        io_units_rst <= 1'b0;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            expect_invalid("fifo cleared", io_unit_out[0]);
        end
        @(posedge clk);
        rs_vals[0] <= fresh;
        rs_data_valid <= 2'b01;
        @(posedge clk);
        rs_data_valid <= '0;
        wait_valid("fifo after clear", 1'b0, 0);
        check_word("fifo after clear", word_of(fresh), io_unit_out[0]);
        pop_fifo();
        expect_invalid("fifo final", io_unit_out[0]);
        load_defaults();
    endtask

    initial begin
        void'($urandom(32'hd417_7321));
        clk = 1'b0;
        num_checks = 0;
        num_errors = 0;
        num_timeouts = 0;
        rst <= 1'b1;
        rs_data_valid <= '0;
        io_units_rst <= 1'b0;
        io_fifo_pop <= '0;
        for (int i = 0; i < rca_pkg::NUM_READ_PORTS; i++) begin
            rs_vals[i] <= '0;
        end
        for (int r = 0; r < rca_pkg::GRID_NUM_ROWS; r++) begin
            io_cfg[r] <= '0;
            for (int c = 0; c < rca_pkg::GRID_NUM_COLS; c++) begin
                slot_cfg[r][c] <= '0;
            end
        end

        reset_behavior();
        pass_through();
        constant_select();
        row0_slot_ops();
        downward_chain();
        fifo_buffering();

        $display("checks: %0d, value errors: %0d, timeouts: %0d",
                 num_checks, num_errors, num_timeouts);
        if (num_errors == 0 && num_timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sim/rca_pr_grid_assertions.sv */
`timescale 1ns/1ns

module rca_pr_grid_assertions (
    input logic clk,
    input logic rst,
    input rca_pkg::grid_word_t data_in,
    input logic output_mode,
    input logic fifo_rst,
    input logic fifo_pop,
    input logic [rca_pkg::FIFO_CNT_W-1:0] fifo_count,
    input rca_pkg::grid_word_t data_out
);

    logic [rca_pkg::FIFO_CNT_W-1:0] model_count;
    logic model_push;
    logic model_pop;

    // occupancy rebuilt from the io unit inputs alone
    assign model_push = output_mode && data_in.valid
                        && (model_count < rca_pkg::FIFO_CNT_W'(rca_pkg::IO_FIFO_DEPTH));
    assign model_pop = fifo_pop && (model_count != '0);

    always_ff @(posedge clk) begin
        if (rst || fifo_rst) begin
            model_count <= '0;
        end else begin
            model_count <= model_count + rca_pkg::FIFO_CNT_W'(model_push)
                           - rca_pkg::FIFO_CNT_W'(model_pop);
        end
    end

    // count may reach the depth but never pass it
    count_in_range: assert property (
        @(posedge clk) disable iff (rst)
        fifo_count <= rca_pkg::FIFO_CNT_W'(rca_pkg::IO_FIFO_DEPTH)
    ) else $error("fifo count %0d above depth", fifo_count);

    // head is shown exactly while entries are held
    fifo_valid_tracks_count: assert property (
        @(posedge clk) disable iff (rst)
        output_mode |-> (data_out.valid == (model_count != '0))
    ) else $error("fifo mode output valid %0b while %0d entries should be held",
                  data_out.valid, model_count);

    valid_low_after_reset: assert property (
        @(posedge clk)
        rst |=> !data_out.valid
    ) else $error("io unit output valid in the cycle after reset");

endmodule

/* hdl/rca_pr_grid.sv */
`timescale 1ns/1ns

module rca_pr_grid (
    input logic clk,
    input logic rst,

    input logic [rca_pkg::XLEN-1:0] rs_vals [rca_pkg::NUM_READ_PORTS],
    input logic [rca_pkg::GRID_NUM_ROWS-1:0] rs_data_valid,

    input rca_pkg::io_cfg_t io_cfg [rca_pkg::GRID_NUM_ROWS],
    input rca_pkg::slot_cfg_t slot_cfg [rca_pkg::GRID_NUM_ROWS][rca_pkg::GRID_NUM_COLS],
    input logic io_units_rst,
    input logic [rca_pkg::GRID_NUM_ROWS-1:0] io_fifo_pop,

    output rca_pkg::grid_word_t io_unit_out [rca_pkg::GRID_NUM_ROWS],
    output rca_pkg::grid_word_t grid_out [rca_pkg::GRID_NUM_COLS]
);

    // entry r holds the slots feeding row r, entry 0 is the empty top edge
    rca_pkg::grid_word_t row_slots [rca_pkg::GRID_NUM_ROWS+1][rca_pkg::GRID_NUM_COLS];

    genvar r;
    genvar c;
    generate
        for (c = 0; c < rca_pkg::GRID_NUM_COLS; c++) begin : top_edge
            assign row_slots[0][c] = rca_pkg::GRID_WORD_NONE;
        end

        for (r = 0; r < rca_pkg::GRID_NUM_ROWS; r++) begin : rows
            grid_row row (
                .clk,
                .rst,
                .rs_vals,
                .rs_valid(rs_data_valid[r]),
                .prev_slots(row_slots[r]),
                .io_cfg(io_cfg[r]),
                .slot_cfg(slot_cfg[r]),
                .fifo_rst(io_units_rst),
                .fifo_pop(io_fifo_pop[r]),
                .io_out(io_unit_out[r]),
                .slot_out(row_slots[r+1])
            );
        end
    endgenerate

    // last row leaves the grid
    assign grid_out = row_slots[rca_pkg::GRID_NUM_ROWS];

endmodule

/* hdl/grid_row.sv */
`timescale 1ns/1ns

module grid_row (
    input logic clk,
    input logic rst,
    input logic [rca_pkg::XLEN-1:0] rs_vals [rca_pkg::NUM_READ_PORTS],
    input logic rs_valid,
    input rca_pkg::grid_word_t prev_slots [rca_pkg::GRID_NUM_COLS],
    input rca_pkg::io_cfg_t io_cfg,
    input rca_pkg::slot_cfg_t slot_cfg [rca_pkg::GRID_NUM_COLS],
    input logic fifo_rst,
    input logic fifo_pop,
    output rca_pkg::grid_word_t io_out,
    output rca_pkg::grid_word_t slot_out [rca_pkg::GRID_NUM_COLS]
);

    localparam int CONST_IDX = rca_pkg::NUM_READ_PORTS + rca_pkg::GRID_NUM_COLS;
    localparam int IO_IDX = rca_pkg::GRID_NUM_COLS;
    localparam int LEFT_IDX = rca_pkg::GRID_NUM_COLS + 1;

    rca_pkg::grid_word_t io_mux_in [rca_pkg::XBAR_NUM_INPUTS];
    rca_pkg::grid_word_t io_mux_out;

    rca_pkg::grid_word_t slot_mux_in [rca_pkg::GRID_NUM_COLS][rca_pkg::XBAR_NUM_INPUTS];
    rca_pkg::grid_word_t slot_opnd1 [rca_pkg::GRID_NUM_COLS];
    rca_pkg::grid_word_t slot_opnd2 [rca_pkg::GRID_NUM_COLS];

    // read ports and the constant share the row valid
    always_comb begin
        for (int i = 0; i < rca_pkg::NUM_READ_PORTS; i++) begin
            io_mux_in[i] = {rs_valid, rs_vals[i]};
        end
        for (int k = 0; k < rca_pkg::GRID_NUM_COLS; k++) begin
            io_mux_in[rca_pkg::NUM_READ_PORTS + k] = prev_slots[k];
        end
        io_mux_in[CONST_IDX] = {rs_valid, io_cfg.row_const};
    end

    grid_xbar_mux io_mux (
        .data_in(io_mux_in),
        .data_sel(io_cfg.mux_sel),
        .data_out(io_mux_out)
    );

    grid_io_block io_unit (
        .clk,
        .rst,
        .data_in(io_mux_out),
        .output_mode(io_cfg.output_mode),
        .fifo_rst,
        .fifo_pop,
        .data_out(io_out)
    );

    // both operand muxes of a slot see the same input vector
    always_comb begin
        for (int j = 0; j < rca_pkg::GRID_NUM_COLS; j++) begin
            for (int k = 0; k < rca_pkg::XBAR_NUM_INPUTS; k++) begin
                slot_mux_in[j][k] = rca_pkg::GRID_WORD_NONE;
            end
            for (int k = 0; k < rca_pkg::GRID_NUM_COLS; k++) begin
                slot_mux_in[j][k] = prev_slots[k];
            end
            slot_mux_in[j][IO_IDX] = io_out;
            // column 0 has no left neighbour
            if (j > 0) begin
                slot_mux_in[j][LEFT_IDX] = slot_out[j-1];
            end
        end
    end

    genvar j;
    generate
        for (j = 0; j < rca_pkg::GRID_NUM_COLS; j++) begin : slots
            grid_xbar_mux opnd1_mux (
                .data_in(slot_mux_in[j]),
                .data_sel(rca_pkg::IO_SEL_W'(slot_cfg[j].sel1)),
                .data_out(slot_opnd1[j])
            );

            grid_xbar_mux opnd2_mux (
                .data_in(slot_mux_in[j]),
                .data_sel(rca_pkg::IO_SEL_W'(slot_cfg[j].sel2)),
                .data_out(slot_opnd2[j])
            );

            grid_pr_slot pr_slot (
                .clk,
                .rst,
                .data_in1(slot_opnd1[j]),
                .data_in2(slot_opnd2[j]),
                .op(slot_cfg[j].op),
                .data_out(slot_out[j])
            );
        end
    endgenerate

endmodule

/* hdl/grid_pr_slot.sv */
`timescale 1ns/1ns

module grid_pr_slot (
    input logic clk,
    input logic rst,
    input rca_pkg::grid_word_t data_in1,
    input rca_pkg::grid_word_t data_in2,
    input rca_pkg::slot_op_t op,
    output rca_pkg::grid_word_t data_out
);

    logic [rca_pkg::XLEN-1:0] op_result;
    logic both_valid;

    assign both_valid = data_in1.valid && data_in2.valid;

    always_comb begin
        case (op)
            rca_pkg::SLOT_ADD: op_result = data_in1.data + data_in2.data;
            rca_pkg::SLOT_SUB: op_result = data_in1.data - data_in2.data;
            rca_pkg::SLOT_XOR: op_result = data_in1.data ^ data_in2.data;
            // keeps only the low word of the product
            rca_pkg::SLOT_MUL: op_result = data_in1.data * data_in2.data;
            default: op_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_out.valid <= 1'b0;
        end else begin
            data_out.valid <= both_valid;
        end
        data_out.data <= op_result;
    end

endmodule

/* hdl/grid_io_block.sv */
`timescale 1ns/1ns

module grid_io_block (
    input logic clk,
    input logic rst,
    input rca_pkg::grid_word_t data_in,
    input logic output_mode,
    input logic fifo_rst,
    input logic fifo_pop,
    output rca_pkg::grid_word_t data_out
);

    rca_pkg::grid_word_t pass_reg;

    logic [rca_pkg::XLEN-1:0] fifo_mem [rca_pkg::IO_FIFO_DEPTH];
    logic [rca_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [rca_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [rca_pkg::FIFO_CNT_W-1:0] fifo_count;
    logic fifo_full;
    logic fifo_empty;
    logic push;
    logic pop;

    assign fifo_full = (fifo_count == rca_pkg::FIFO_CNT_W'(rca_pkg::IO_FIFO_DEPTH));
    assign fifo_empty = (fifo_count == '0);

    // a push into a full fifo is lost since there is no back-pressure
    assign push = output_mode && data_in.valid && !fifo_full;
    assign pop = fifo_pop && !fifo_empty;

    // pass path
    always_ff @(posedge clk) begin
        if (rst) begin
            pass_reg.valid <= 1'b0;
        end else begin
            pass_reg.valid <= data_in.valid;
        end
        pass_reg.data <= data_in.data;
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= data_in.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || fifo_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: fifo_count <= fifo_count + 1'b1;
                2'b01: fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    // head of the fifo is visible while anything is buffered
    always_comb begin
        if (output_mode) begin
            data_out.valid = !fifo_empty;
            data_out.data = fifo_mem[rd_ptr];
        end else begin
            data_out = pass_reg;
        end
    end

endmodule

/* hdl/grid_xbar_mux.sv */
`timescale 1ns/1ns

module grid_xbar_mux (
    input rca_pkg::grid_word_t data_in [rca_pkg::XBAR_NUM_INPUTS],
    input logic [rca_pkg::IO_SEL_W-1:0] data_sel,
    output rca_pkg::grid_word_t data_out
);

    // valid and data move together, an unmatched select yields an empty word
    always_comb begin
        data_out = rca_pkg::GRID_WORD_NONE;
        for (int i = 0; i < $size(data_in); i++) begin
            if (data_sel == rca_pkg::IO_SEL_W'(i)) begin
                data_out = data_in[i];
            end
        end
    end

endmodule

/* hdl/rca_pkg.sv */
package rca_pkg;

    // data word and grid shape
    localparam int XLEN = 32;
    localparam int GRID_NUM_ROWS = 2;
    localparam int GRID_NUM_COLS = 2;
    localparam int NUM_READ_PORTS = 2;

    // io mux inputs are the read ports, then the previous row slots, then the row constant
    localparam int IO_UNIT_MUX_INPUTS = NUM_READ_PORTS + GRID_NUM_COLS + 1;

    // slot mux inputs are the previous row slots, then the own io unit, then the left neighbour
    localparam int GRID_MUX_INPUTS = GRID_NUM_COLS + 2;

    // one mux module serves both sizes and its vector fits the larger one
    localparam int XBAR_NUM_INPUTS = IO_UNIT_MUX_INPUTS;

    localparam int IO_SEL_W = $clog2(IO_UNIT_MUX_INPUTS);
    localparam int SLOT_SEL_W = $clog2(GRID_MUX_INPUTS);

    localparam int IO_FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(IO_FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(IO_FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        SLOT_ADD = 2'd0,
        SLOT_SUB = 2'd1, // operand 1 minus operand 2
        SLOT_XOR = 2'd2,
        SLOT_MUL = 2'd3  // low word of the product
    } slot_op_t;

    // word carried on every grid wire
    typedef struct packed {
        logic valid;
        logic [XLEN-1:0] data;
    } grid_word_t;

    localparam grid_word_t GRID_WORD_NONE = '0;

    typedef struct packed {
        logic [IO_SEL_W-1:0] mux_sel;
        logic output_mode; // 0 pass, 1 fifo
        logic [XLEN-1:0] row_const;
    } io_cfg_t;

    typedef struct packed {
        logic [SLOT_SEL_W-1:0] sel1;
        logic [SLOT_SEL_W-1:0] sel2;
        slot_op_t op;
    } slot_cfg_t;

endpackage
